/* rtl/div_pkg.sv */
// shared opcode and core state types, imported by the divider RTL and its testbench
package div_pkg;

    // bit 1 set means signed, bit 0 set means remainder
    typedef enum logic [1:0] {
        DIV_U = 2'b00,
        REM_U = 2'b01,
        DIV_S = 2'b10,
        REM_S = 2'b11
    } div_op_e;

    // control states of the restoring core
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        COMPUTE = 2'b01,
        DONE    = 2'b10
    } div_core_state_e;

endpackage

/* rtl/div_operand_stage.sv */
// command input register of the divider, turns signed operands into magnitudes plus sign flags
`timescale 1ns/1ps

module div_operand_stage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  div_pkg::div_op_e in_op,
    input  logic [WIDTH-1:0] in_dividend,
    input  logic [WIDTH-1:0] in_divisor,
    input  logic             op_ready,
    output logic             in_ready,
    output logic             op_valid,
    output logic [WIDTH-1:0] op_dividend_mag,
    output logic [WIDTH-1:0] op_divisor_mag,
    output logic             side_valid,
    output div_pkg::div_op_e side_op,
    output logic             side_neg_quot,
    output logic             side_neg_rem,
    output logic             side_div_zero,
    output logic [WIDTH-1:0] side_dividend
);
    import div_pkg::*;

    logic             is_signed;
    logic             dvd_neg;
    logic             dvs_neg;
    logic             load;
    logic [WIDTH-1:0] dvd_mag;
    logic [WIDTH-1:0] dvs_mag;

    assign is_signed = (in_op == DIV_S) || (in_op == REM_S);
    assign dvd_neg   = is_signed && in_dividend[WIDTH-1];
    assign dvs_neg   = is_signed && in_divisor[WIDTH-1];

    // two's complement magnitude, most negative value maps onto itself
    assign dvd_mag = dvd_neg ? (~in_dividend + 1'b1) : in_dividend;
    assign dvs_mag = dvs_neg ? (~in_divisor + 1'b1) : in_divisor;

    // slot can refill in the same cycle the core takes it
    assign in_ready = !op_valid || op_ready;
    assign load     = in_valid && in_ready;

    // tells the result stage to capture the sideband of the command entering the core
    assign side_valid = op_valid && op_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (load) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_dividend_mag <= dvd_mag;
            op_divisor_mag  <= dvs_mag;
            side_op         <= in_op;
            side_neg_quot   <= dvd_neg ^ dvs_neg;
            side_neg_rem    <= dvd_neg;
            side_div_zero   <= (in_divisor == '0);
            side_dividend   <= in_dividend;
        end
    end

    // held command must not change before the core takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && !op_ready |=> op_valid && $stable(op_dividend_mag)
                                  && $stable(op_divisor_mag));

endmodule

/* rtl/div_restoring_core.sv */
// iterative restoring divider of unsigned magnitudes used by div_unit to form one quotient bit per clock
`timescale 1ns/1ps

module div_restoring_core #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  logic [WIDTH-1:0] op_dividend_mag,
    input  logic [WIDTH-1:0] op_divisor_mag,
    input  logic             core_ready,
    output logic             op_ready,
    output logic             core_valid,
    output logic [WIDTH-1:0] core_quotient,
    output logic [WIDTH-1:0] core_remainder
);
    import div_pkg::*;

    localparam int CNT_W = $clog2(WIDTH + 1);

    div_core_state_e  state;
    logic [CNT_W-1:0] cnt;
    logic [WIDTH-1:0] divisor_q;
    logic [WIDTH-1:0] quo_q;
    logic [WIDTH-1:0] rem_q;
    logic [WIDTH:0]   shifted;
    logic [WIDTH+1:0] diff;
    logic             borrow;

    // next dividend bit comes out of the top of the quotient register
    assign shifted = {rem_q, quo_q[WIDTH-1]};

    // trial subtraction with the borrow known in the same cycle
    assign diff   = {1'b0, shifted} - {2'b00, divisor_q};
    assign borrow = diff[WIDTH+1];

    assign op_ready       = (state == IDLE);
    assign core_valid     = (state == DONE);
    assign core_quotient  = quo_q;
    assign core_remainder = rem_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (op_valid) begin
                        state <= COMPUTE;
                        cnt   <= '0;
                    end
                end
                COMPUTE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (core_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // quotient bits shift in from the bottom as dividend bits leave the top
    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            quo_q     <= op_dividend_mag;
            rem_q     <= '0;
            divisor_q <= op_divisor_mag;
        end else if (state == COMPUTE) begin
            // on borrow the shifted value is below the divisor and fits WIDTH bits
            rem_q <= borrow ? shifted[WIDTH-1:0] : diff[WIDTH-1:0];
            quo_q <= {quo_q[WIDTH-2:0], ~borrow};
        end
    end

    // result only after a full run of iterations
    assert property (@(posedge clk) disable iff (!rst_n)
        core_valid |-> cnt == CNT_W'(WIDTH));

    assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= CNT_W'(WIDTH));

    // fixed latency from accept to result
    assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && op_ready |-> ##(WIDTH + 1) core_valid);

endmodule

/* rtl/div_result_stage.sv */
// result output register, restores signs, applies the zero-divisor rule and selects by opcode
`timescale 1ns/1ps

module div_result_stage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             core_valid,
    input  logic [WIDTH-1:0] core_quotient,
    input  logic [WIDTH-1:0] core_remainder,
    input  logic             out_ready,
    input  logic             side_valid,
    input  div_pkg::div_op_e side_op,
    input  logic             side_neg_quot,
    input  logic             side_neg_rem,
    input  logic             side_div_zero,
    input  logic [WIDTH-1:0] side_dividend,
    output logic             core_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_result
);
    import div_pkg::*;

    // sideband of the one command inside the core
    div_op_e          op_q;
    logic             neg_quot_q;
    logic             neg_rem_q;
    logic             div_zero_q;
    logic [WIDTH-1:0] dividend_q;
    logic             side_full;

    logic             take;
    logic [WIDTH-1:0] quot_fix;
    logic [WIDTH-1:0] rem_fix;
    logic [WIDTH-1:0] result;

    assign core_ready = !out_valid || out_ready;
    assign take       = core_valid && core_ready;

    // zero divisor keeps the core's all-ones quotient as is
    assign quot_fix = (neg_quot_q && !div_zero_q) ? (~core_quotient + 1'b1) : core_quotient;

    always_comb begin
        if (div_zero_q) begin
            rem_fix = dividend_q;
        end else if (neg_rem_q) begin
            rem_fix = ~core_remainder + 1'b1;
        end else begin
            rem_fix = core_remainder;
        end
    end

    always_comb begin
        case (op_q)
            DIV_U, DIV_S: result = quot_fix;
            REM_U, REM_S: result = rem_fix;
            default:      result = quot_fix;
        endcase
    end

    always_ff @(posedge clk) begin
        if (side_valid) begin
            op_q       <= side_op;
            neg_quot_q <= side_neg_quot;
            neg_rem_q  <= side_neg_rem;
            div_zero_q <= side_div_zero;
            dividend_q <= side_dividend;
        end
        if (take) begin
            out_result <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            side_full <= 1'b0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (side_valid) begin
                side_full <= 1'b1;
            end else if (take) begin
                side_full <= 1'b0;
            end
        end
    end

    // core result must always have matching sideband
    assert property (@(posedge clk) disable iff (!rst_n)
        core_valid |-> side_full);

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result));

endmodule

/* rtl/div_unit.sv */
// top of the 8-bit class integer divider, chains operand stage, restoring core and result stage
`timescale 1ns/1ps

module div_unit #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  div_pkg::div_op_e in_op,
    input  logic [WIDTH-1:0] in_dividend,
    input  logic [WIDTH-1:0] in_divisor,
    input  logic             out_ready,
    output logic             in_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_result
);
    import div_pkg::*;

    logic             op_valid;
    logic             op_ready;
    logic [WIDTH-1:0] op_dividend_mag;
    logic [WIDTH-1:0] op_divisor_mag;

    logic             side_valid;
    div_op_e          side_op;
    logic             side_neg_quot;
    logic             side_neg_rem;
    logic             side_div_zero;
    logic [WIDTH-1:0] side_dividend;

    logic             core_valid;
    logic             core_ready;
    logic [WIDTH-1:0] core_quotient;
    logic [WIDTH-1:0] core_remainder;

    div_operand_stage #(
        .WIDTH(WIDTH)
    ) u_operand (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_dividend    (in_dividend),
        .in_divisor     (in_divisor),
        .op_ready       (op_ready),
        .in_ready       (in_ready),
        .op_valid       (op_valid),
        .op_dividend_mag(op_dividend_mag),
        .op_divisor_mag (op_divisor_mag),
        .side_valid     (side_valid),
        .side_op        (side_op),
        .side_neg_quot  (side_neg_quot),
        .side_neg_rem   (side_neg_rem),
        .side_div_zero  (side_div_zero),
        .side_dividend  (side_dividend)
    );

    div_restoring_core #(
        .WIDTH(WIDTH)
    ) u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op_dividend_mag(op_dividend_mag),
        .op_divisor_mag (op_divisor_mag),
        .core_ready     (core_ready),
        .op_ready       (op_ready),
        .core_valid     (core_valid),
        .core_quotient  (core_quotient),
        .core_remainder (core_remainder)
    );

    div_result_stage #(
        .WIDTH(WIDTH)
    ) u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_valid    (core_valid),
        .core_quotient (core_quotient),
        .core_remainder(core_remainder),
        .out_ready     (out_ready),
        .side_valid    (side_valid),
        .side_op       (side_op),
        .side_neg_quot (side_neg_quot),
        .side_neg_rem  (side_neg_rem),
        .side_div_zero (side_div_zero),
        .side_dividend (side_dividend),
        .core_ready    (core_ready),
        .out_valid     (out_valid),
        .out_result    (out_result)
    );

endmodule

/* verification/div_unit_tb.sv */
// self-checking testbench of div_unit, replays the command trace with random handshake timing
`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    localparam int WIDTH      = 8;
    localparam int MAX_CMDS   = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int LATENCY    = WIDTH + 2;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    div_op_e          in_op;
    logic [WIDTH-1:0] in_dividend;
    logic [WIDTH-1:0] in_divisor;
    logic             in_ready;
    logic             out_valid;
    logic             out_ready;
    logic [WIDTH-1:0] out_result;

    logic             trc_isolated[MAX_CMDS];
    logic [1:0]       trc_op[MAX_CMDS];
    logic [WIDTH-1:0] trc_dividend[MAX_CMDS];
    logic [WIDTH-1:0] trc_divisor[MAX_CMDS];
    logic [WIDTH-1:0] expected_q[$];
    int               num_cmds;
    logic [31:0]      lfsr;

    div_unit #(
        .WIDTH(WIDTH)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_dividend(in_dividend),
        .in_divisor (in_divisor),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    // ready one cycle in eight, long stalls fill the pipeline
    function automatic logic draw_ready();
        logic r;
        r = rand_bit();
        r = rand_bit() & r;
        r = rand_bit() & r;
        return r;
    endfunction

    function automatic logic draw_offer();
        logic r;
        r = rand_bit();
        r = rand_bit() | r;
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_trace();
        int               fd;
        int               code;
        logic [8*120-1:0] line;
        logic [31:0]      f_mode;
        logic [31:0]      f_op;
        logic [31:0]      f_dvd;
        logic [31:0]      f_dvs;
        logic [31:0]      f_exp;
        fd = $fopen("verification/div_trace.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the trace file verification/div_trace.txt");
        end
        num_cmds = 0;
        while (!$feof(fd)) begin
            line = '0;
            code = $fgets(line, fd);
            // comment and blank lines do not scan as five fields
            if (code > 0) begin
                code = $sscanf(line, "%h %h %h %h %h", f_mode, f_op, f_dvd, f_dvs, f_exp);
                if (code == 5) begin
                    if (num_cmds >= MAX_CMDS) begin
                        stop_with_error("trace holds more commands than the testbench stores");
                    end
                    trc_isolated[num_cmds] = f_mode[0];
                    trc_op[num_cmds]       = f_op[1:0];
                    trc_dividend[num_cmds] = f_dvd[WIDTH-1:0];
                    trc_divisor[num_cmds]  = f_dvs[WIDTH-1:0];
                    expected_q.push_back(f_exp[WIDTH-1:0]);
                    num_cmds++;
                end
            end
        end
        $fclose(fd);
        if (num_cmds == 0) begin
            stop_with_error("trace file holds no commands");
        end
    endtask

    task automatic drive_command(input int idx);
        in_valid    = 1'b1;
        in_op       = div_op_e'(trc_op[idx]);
        in_dividend = trc_dividend[idx];
        in_divisor  = trc_divisor[idx];
    endtask

    task automatic check_result();
        logic [WIDTH-1:0] exp;
        if (expected_q.size() == 0) begin
            stop_with_error("a result appeared with no command outstanding");
        end
        exp = expected_q.pop_front();
        check_value("out_result", 32'(out_result), 32'(exp));
    endtask

    // one command through an empty pipeline, latency counted from the in transfer edge
    task automatic run_isolated(input int idx);
        int cycles;
        drive_command(idx);
        out_ready = 1'b1;
        cycles    = 0;
        while (!in_ready) begin
            next_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("command not accepted within 200 cycles");
            end
        end
        next_cycle();
        in_valid = 1'b0;
        cycles   = 0;
        while (!out_valid) begin
            next_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("no result within 200 cycles");
            end
        end
        check_value("latency", 32'(cycles), 32'(LATENCY));
        check_result();
        next_cycle();
        check_value("out_valid", 32'(out_valid), 32'h0);
        repeat (3) next_cycle();
    endtask

    task automatic run_stream(input int first);
        int               next_idx;
        int               delivered;
        int               in_flight;
        int               max_in_flight;
        int               idle;
        logic             in_take;
        logic             out_take;
        logic             held;
        logic [WIDTH-1:0] held_result;
        next_idx      = first;
        delivered     = first;
        in_flight     = 0;
        max_in_flight = 0;
        idle          = 0;
        in_take       = 1'b0;
        held          = 1'b0;
        held_result   = '0;
        while (delivered < num_cmds) begin
            // a stalled result must not move
            if (held) begin
                check_value("out_valid", 32'(out_valid), 32'h1);
                check_value("out_result", 32'(out_result), 32'(held_result));
            end
            out_ready = draw_ready();
            if (out_valid && out_ready) begin
                check_result();
            end
            held        = out_valid && !out_ready;
            held_result = out_result;
            // every stage holds a command
            if (in_flight == 3) begin
                check_value("in_ready", 32'(in_ready), 32'h0);
            end
            // an offer not yet taken stays on the port unchanged
            if (!in_valid || in_take) begin
                if (next_idx < num_cmds && draw_offer()) begin
                    drive_command(next_idx);
                end else begin
                    in_valid = 1'b0;
                end
            end
            in_take  = in_valid && in_ready;
            out_take = out_valid && out_ready;
            next_cycle();
            idle++;
            if (idle > WAIT_LIMIT) begin
                stop_with_error("no result within 200 cycles");
            end
            if (in_take) begin
                next_idx++;
                in_flight++;
            end
            if (out_take) begin
                delivered++;
                in_flight--;
                idle = 0;
            end
            if (in_flight > max_in_flight) begin
                max_in_flight = in_flight;
            end
        end
        in_valid = 1'b0;
        check_value("commands in flight", 32'(in_flight), 32'h0);
        check_value("expected results left", 32'(expected_q.size()), 32'h0);
        check_value("peak commands in flight", 32'(max_in_flight), 32'h3);
    endtask

    initial begin
        int idx;
        lfsr        = 32'h7e96_6036;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = DIV_U;
        in_dividend = '0;
        in_divisor  = '0;
        out_ready   = 1'b0;
        load_trace();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("in_ready", 32'(in_ready), 32'h1);
        idx = 0;
        while (idx < num_cmds && trc_isolated[idx]) begin
            run_isolated(idx);
            idx++;
        end
        run_stream(idx);
        // nothing more may come out
        out_ready = 1'b1;
        repeat (30) begin
            next_cycle();
            check_value("out_valid", 32'(out_valid), 32'h0);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* verification/div_trace.txt */
// columns in hex: mode op dividend divisor expected, op 0 DIV_U 1 REM_U 2 DIV_S 3 REM_S
// mode 1 lines come first and run one at a time through an empty pipeline
1 0 64 07 0e
1 1 64 07 02
1 2 9c 07 f2
1 3 9c 07 fe
0 0 c8 0d 0f
0 1 c8 0d 05
0 0 ff 01 ff
0 1 ff 01 00
0 0 05 09 00
0 1 05 09 05
0 0 ff ff 01
0 1 ff 10 0f
0 0 80 03 2a
0 1 80 03 02
0 1 e7 fe e7
0 2 11 05 03
0 3 11 05 02
0 2 ef 05 fd
0 3 ef 05 fe
0 2 11 fb fd
0 3 11 fb 02
0 2 ef fb 03
0 3 ef fb fe
0 2 80 ff 80
0 3 80 ff 00
0 2 80 01 80
0 3 80 07 fe
0 2 7f 81 ff
0 3 7f 81 00
0 2 03 fc 00
0 3 f9 02 ff
0 0 5a 00 ff
0 1 5a 00 5a
0 2 a6 00 ff
0 3 a6 00 a6
0 2 35 00 ff
0 3 00 00 00

/* list.f */
rtl/div_pkg.sv
rtl/div_operand_stage.sv
rtl/div_restoring_core.sv
rtl/div_result_stage.sv
rtl/div_unit.sv
verification/div_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module div_unit_tb -f list.f -o div_unit_sim

sim_out=$(./obj_dir/div_unit_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Test OK'; then
    exit 0
fi
exit 1
